// File: rtl/axi_bus_pkg.sv
// ################################################
// AXI4 write bus field types
// Address, length, data and response widths plus
// the response codes used on the write channels
// ################################################

package axi_bus_pkg;

    // Byte address on AW
    typedef logic [31:0] addr_t;

    // AWLEN field, beats minus one
    typedef logic [7:0] len_t;

    // One beat on W
    typedef logic [31:0] data_t;

    // BRESP code
    typedef logic [1:0] resp_t;

    // Response codes
    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

endpackage

// File: rtl/partition_pkg.sv
// ################################################
// Burst partitioner internal types
// Controller states and beat counters
// ################################################

package partition_pkg;

    // Controller FSM, one path per piece kind
    typedef enum logic [3:0] {
        idle,
        take_request,
        split_addr,
        split_data,
        split_resp,
        last_addr,
        last_data,
        last_resp,
        one_addr,
        one_data,
        one_resp,
        up_resp
    } part_state_t;

    // Holds 0 to 256 beats
    typedef logic [8:0] beat_cnt_t;

endpackage

// File: rtl/wr_beat_splitter.sv
// ################################################
// W channel beat splitter
// Passes write beats while enabled and marks the
// final beat of every downstream piece
// ################################################

`timescale 1ns/1ps

module wr_beat_splitter
    import axi_bus_pkg::*;
    import partition_pkg::*;
#(
    parameter int PART_LEN = 16
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  data_enable,
    // Upstream W
    input  logic  up_wvalid,
    output logic  up_wready,
    input  data_t up_wdata,
    input  logic  up_wlast,
    // Downstream W
    output logic  dn_wvalid,
    input  logic  dn_wready,
    output data_t dn_wdata,
    output logic  dn_wlast,
    // To controller
    output logic  piece_done
);

    localparam beat_cnt_t LAST_IDX = beat_cnt_t'(PART_LEN - 1);

    beat_cnt_t beat_cnt_q;
    logic      beat_xfer;

    // Handshake only opens during a data phase
    assign dn_wvalid = data_enable & up_wvalid;
    assign up_wready = data_enable & dn_wready;
    assign dn_wdata  = up_wdata;

    // Piece ends on a full count or the end of the upstream burst
    assign dn_wlast = (beat_cnt_q == LAST_IDX) | up_wlast;

    assign beat_xfer  = dn_wvalid & dn_wready;
    assign piece_done = beat_xfer & dn_wlast;

    // Beat index within the current piece
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt_q <= '0;
        end else if (beat_xfer) begin
            if (dn_wlast) begin
                beat_cnt_q <= '0;
            end else begin
                beat_cnt_q <= beat_cnt_q + beat_cnt_t'(1);
            end
        end
    end

endmodule

// File: rtl/wr_partition_ctrl.sv
// ################################################
// Write burst partition controller
// Splits one upstream AW request into downstream
// pieces and merges their B responses into one
// ################################################

`timescale 1ns/1ps

module wr_partition_ctrl
    import axi_bus_pkg::*;
    import partition_pkg::*;
#(
    parameter int PART_LEN   = 16,
    parameter int BEAT_BYTES = 4
) (
    input  logic  clock,
    input  logic  rst_n,
    // Upstream AW and B
    input  logic  up_awvalid,
    output logic  up_awready,
    input  addr_t up_awaddr,
    input  len_t  up_awlen,
    output logic  up_bvalid,
    input  logic  up_bready,
    output resp_t up_bresp,
    // Downstream AW and B
    output logic  dn_awvalid,
    input  logic  dn_awready,
    output addr_t dn_awaddr,
    output len_t  dn_awlen,
    input  logic  dn_bvalid,
    output logic  dn_bready,
    input  resp_t dn_bresp,
    // Splitter handshake
    input  logic  piece_done,
    output logic  data_enable
);

    localparam beat_cnt_t PART_BEATS = beat_cnt_t'(PART_LEN);
    localparam len_t      PART_AWLEN = len_t'(PART_LEN - 1);
    localparam addr_t     ADDR_STEP  = addr_t'(PART_LEN * BEAT_BYTES);

    part_state_t state_q;
    part_state_t state_d;

    beat_cnt_t remain_q;
    addr_t     addr_q;
    logic      resp_err_q;

    logic up_aw_xfer;
    logic dn_aw_xfer;
    logic dn_b_xfer;
    logic up_b_xfer;

    assign up_aw_xfer = up_awvalid & up_awready;
    assign dn_aw_xfer = dn_awvalid & dn_awready;
    assign dn_b_xfer  = dn_bvalid & dn_bready;
    assign up_b_xfer  = up_bvalid & up_bready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (up_aw_xfer) begin
                    state_d = take_request;
                end
            end
            // Length decides between split and single piece
            take_request: begin
                if (remain_q > PART_BEATS) begin
                    state_d = split_addr;
                end else begin
                    state_d = one_addr;
                end
            end
            split_addr: begin
                if (dn_aw_xfer) begin
                    state_d = split_data;
                end
            end
            split_data: begin
                if (piece_done) begin
                    state_d = split_resp;
                end
            end
            split_resp: begin
                if (dn_b_xfer) begin
                    // Remainder fits in one more piece
                    if (remain_q <= PART_BEATS) begin
                        state_d = last_addr;
                    end else begin
                        state_d = split_addr;
                    end
                end
            end
            last_addr: begin
                if (dn_aw_xfer) begin
                    state_d = last_data;
                end
            end
            last_data: begin
                if (piece_done) begin
                    state_d = last_resp;
                end
            end
            last_resp: begin
                if (dn_b_xfer) begin
                    state_d = up_resp;
                end
            end
            one_addr: begin
                if (dn_aw_xfer) begin
                    state_d = one_data;
                end
            end
            one_data: begin
                if (piece_done) begin
                    state_d = one_resp;
                end
            end
            one_resp: begin
                if (dn_b_xfer) begin
                    state_d = up_resp;
                end
            end
            up_resp: begin
                if (up_b_xfer) begin
                    state_d = idle;
                end
            end
            default: state_d = idle;
        endcase
    end

    // Handshake outputs follow the next state
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            up_awready  <= 1'b0;
            up_bvalid   <= 1'b0;
            dn_awvalid  <= 1'b0;
            dn_bready   <= 1'b0;
            data_enable <= 1'b0;
        end else begin
            up_awready  <= (state_d == idle);
            up_bvalid   <= (state_d == up_resp);
            dn_awvalid  <= state_d inside {split_addr, last_addr, one_addr};
            dn_bready   <= state_d inside {split_resp, last_resp, one_resp};
            data_enable <= state_d inside {split_data, last_data, one_data};
        end
    end

    // Beats still to be issued downstream
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            remain_q <= '0;
        end else if (up_aw_xfer) begin
            remain_q <= beat_cnt_t'({1'b0, up_awlen}) + beat_cnt_t'(1);
        end else if (dn_aw_xfer) begin
            if (remain_q >= PART_BEATS) begin
                remain_q <= remain_q - PART_BEATS;
            end else begin
                remain_q <= '0;
            end
        end
    end

    // Start address of the next piece
    always_ff @(posedge clock) begin
        if (up_aw_xfer) begin
            addr_q <= up_awaddr;
        end else if (dn_aw_xfer) begin
            addr_q <= addr_q + ADDR_STEP;
        end
    end

    // Sticky error over all pieces of the burst
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            resp_err_q <= 1'b0;
        end else if (up_aw_xfer) begin
            resp_err_q <= 1'b0;
        end else if (dn_b_xfer && (dn_bresp != resp_okay)) begin
            resp_err_q <= 1'b1;
        end
    end

    // remain_q only moves on an AW transfer, so these hold while awvalid is high
    assign dn_awaddr = addr_q;
    assign dn_awlen  = (remain_q >= PART_BEATS) ? PART_AWLEN
                                                : len_t'(remain_q - beat_cnt_t'(1));

    assign up_bresp = resp_err_q ? resp_slverr : resp_okay;

endmodule

// File: rtl/axi_wr_partition_top.sv
// ################################################
// AXI4 write burst partitioner
// Cuts one upstream write burst into downstream
// bursts of at most PART_LEN beats and returns a
// single merged response
// ################################################

`timescale 1ns/1ps

module axi_wr_partition_top
    import axi_bus_pkg::*;
#(
    parameter int PART_LEN   = 16,
    parameter int BEAT_BYTES = 4
) (
    input  logic  clock,
    input  logic  rst_n,
    // Upstream slave side
    input  logic  up_awvalid,
    output logic  up_awready,
    input  addr_t up_awaddr,
    input  len_t  up_awlen,
    input  logic  up_wvalid,
    output logic  up_wready,
    input  data_t up_wdata,
    input  logic  up_wlast,
    output logic  up_bvalid,
    input  logic  up_bready,
    output resp_t up_bresp,
    // Downstream master side
    output logic  dn_awvalid,
    input  logic  dn_awready,
    output addr_t dn_awaddr,
    output len_t  dn_awlen,
    output logic  dn_wvalid,
    input  logic  dn_wready,
    output data_t dn_wdata,
    output logic  dn_wlast,
    input  logic  dn_bvalid,
    output logic  dn_bready,
    input  resp_t dn_bresp
);

    logic data_enable;
    logic piece_done;

    wr_partition_ctrl #(
        .PART_LEN   (PART_LEN),
        .BEAT_BYTES (BEAT_BYTES)
    ) u_ctrl (
        .clock       (clock),
        .rst_n       (rst_n),
        .up_awvalid  (up_awvalid),
        .up_awready  (up_awready),
        .up_awaddr   (up_awaddr),
        .up_awlen    (up_awlen),
        .up_bvalid   (up_bvalid),
        .up_bready   (up_bready),
        .up_bresp    (up_bresp),
        .dn_awvalid  (dn_awvalid),
        .dn_awready  (dn_awready),
        .dn_awaddr   (dn_awaddr),
        .dn_awlen    (dn_awlen),
        .dn_bvalid   (dn_bvalid),
        .dn_bready   (dn_bready),
        .dn_bresp    (dn_bresp),
        .piece_done  (piece_done),
        .data_enable (data_enable)
    );

    wr_beat_splitter #(
        .PART_LEN (PART_LEN)
    ) u_splitter (
        .clock       (clock),
        .rst_n       (rst_n),
        .data_enable (data_enable),
        .up_wvalid   (up_wvalid),
        .up_wready   (up_wready),
        .up_wdata    (up_wdata),
        .up_wlast    (up_wlast),
        .dn_wvalid   (dn_wvalid),
        .dn_wready   (dn_wready),
        .dn_wdata    (dn_wdata),
        .dn_wlast    (dn_wlast),
        .piece_done  (piece_done)
    );

endmodule

// File: verification/axi_wr_slave_model.sv
// ################################################
// Downstream AXI4 write slave model
// Stalls its ready and valid outputs at random,
// records every burst and beat, fails one piece
// ################################################

`timescale 1ns/1ps

module axi_wr_slave_model
    import axi_bus_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  logic  dn_awvalid,
    output logic  dn_awready,
    input  addr_t dn_awaddr,
    input  len_t  dn_awlen,
    input  logic  dn_wvalid,
    output logic  dn_wready,
    input  data_t dn_wdata,
    input  logic  dn_wlast,
    output logic  dn_bvalid,
    input  logic  dn_bready,
    output resp_t dn_bresp,
    // Global index of the response to fail, -1 for none
    input  int    fail_index
);

    // Recorded traffic, read by the testbench
    addr_t aw_addr_q[$];
    len_t  aw_len_q[$];
    data_t w_data_q[$];
    logic  w_last_q[$];

    int     b_count;
    int     pending_b;
    logic   b_taken;
    integer seed;

    initial begin
        seed       = 32'h8927;
        b_count    = 0;
        pending_b  = 0;
        b_taken    = 1'b0;
        dn_awready = 1'b0;
        dn_wready  = 1'b0;
        dn_bvalid  = 1'b0;
        dn_bresp   = resp_okay;
    end

    // Transfers are taken on the rising edge
    always @(posedge clock) begin
        if (rst_n) begin
            if (dn_awvalid && dn_awready) begin
                aw_addr_q.push_back(dn_awaddr);
                aw_len_q.push_back(dn_awlen);
            end
            if (dn_wvalid && dn_wready) begin
                w_data_q.push_back(dn_wdata);
                w_last_q.push_back(dn_wlast);
                if (dn_wlast) begin
                    pending_b = pending_b + 1;
                end
            end
            if (dn_bvalid && dn_bready) begin
                b_count = b_count + 1;
                b_taken = 1'b1;
            end
        end
    end

    // Outputs change on the falling edge
    always @(negedge clock) begin
        if (!rst_n) begin
            dn_awready = 1'b0;
            dn_wready  = 1'b0;
            dn_bvalid  = 1'b0;
            dn_bresp   = resp_okay;
        end else begin
            dn_awready = ($random(seed) & 3) != 0;
            dn_wready  = ($random(seed) & 3) != 0;
            if (dn_bvalid && b_taken) begin
                dn_bvalid = 1'b0;
                b_taken   = 1'b0;
            end
            // Response only after the piece's final beat
            if (!dn_bvalid && (pending_b > 0) && (($random(seed) & 1) != 0)) begin
                dn_bvalid = 1'b1;
                dn_bresp  = (b_count == fail_index) ? resp_slverr : resp_okay;
                pending_b = pending_b - 1;
            end
        end
    end

endmodule

// File: verification/tb_axi_wr_partition.sv
// ################################################
// Testbench for the AXI4 write burst partitioner
// Table of upstream bursts against a stalling slave
// ################################################

`timescale 1ns/1ps

module tb_axi_wr_partition
    import axi_bus_pkg::*;
();

    localparam int PART_LEN   = 4;
    localparam int BEAT_BYTES = 4;
    localparam int N_ROWS     = 7;

    logic  clock;
    logic  rst_n;
    logic  up_awvalid, up_awready, up_wvalid, up_wready, up_wlast;
    logic  up_bvalid, up_bready;
    addr_t up_awaddr;
    len_t  up_awlen;
    data_t up_wdata;
    resp_t up_bresp;
    logic  dn_awvalid, dn_awready, dn_wvalid, dn_wready, dn_wlast;
    logic  dn_bvalid, dn_bready;
    addr_t dn_awaddr;
    len_t  dn_awlen;
    data_t dn_wdata;
    resp_t dn_bresp;
    int    fail_index;

    // Stimulus table with start address, AWLEN, failing piece and expected BRESP
    addr_t tbl_addr[N_ROWS];
    len_t  tbl_len[N_ROWS];
    int    tbl_fail[N_ROWS];
    resp_t tbl_resp[N_ROWS];

    int     error_cnt = 0;
    int     check_cnt = 0;
    int     cycle_cnt = 0;
    int     cycle_limit = 1000000;
    int     up_b_count = 0;
    int     b_expect_total = 0;
    logic   busy = 1'b0;
    integer seed = 32'h8927;

    axi_wr_partition_top #(
        .PART_LEN   (PART_LEN),
        .BEAT_BYTES (BEAT_BYTES)
    ) u_dut (.*);

    axi_wr_slave_model u_slave (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic set_row(input int idx, input addr_t addr, input len_t len,
                           input int fail, input resp_t resp);
        tbl_addr[idx] = addr;
        tbl_len[idx]  = len;
        tbl_fail[idx] = fail;
        tbl_resp[idx] = resp;
    endtask

    task automatic send_request(input addr_t addr, input len_t len);
        @(negedge clock);
        up_awvalid = 1'b1;
        up_awaddr  = addr;
        up_awlen   = len;
        do begin
            @(posedge clock);
        end while (!up_awready);
        @(negedge clock);
        up_awvalid = 1'b0;
    endtask

    task automatic send_beats(input addr_t start, input int n_beats);
        for (int i = 0; i < n_beats; i++) begin
            @(negedge clock);
            up_wvalid = 1'b1;
            up_wdata  = start + data_t'(i);
            up_wlast  = (i == n_beats - 1);
            do begin
                @(posedge clock);
            end while (!up_wready);
        end
        @(negedge clock);
        up_wvalid = 1'b0;
        up_wlast  = 1'b0;
    endtask

    // Random BREADY delay before taking one response
    task automatic take_response(input resp_t exp_resp);
        do begin
            @(negedge clock);
            up_bready = (($random(seed) & 1) != 0);
            @(posedge clock);
        end while (!(up_bvalid && up_bready));
        check_value("up_bresp", up_bresp, exp_resp);
        check_value("dn_b count", u_slave.b_count, b_expect_total);
        @(negedge clock);
        up_bready = 1'b0;
    endtask

    // Pieces follow the splitting rule from the request alone
    task automatic check_burst(input int row, input int piece_base, input int beat_base);
        int remaining;
        int exp_beats;
        int beat_i;
        remaining = int'(tbl_len[row]) + 1;
        beat_i    = 0;
        check_value("dn_aw count", u_slave.aw_addr_q.size(),
                    piece_base + (remaining + PART_LEN - 1) / PART_LEN);
        check_value("dn_w count", u_slave.w_data_q.size(), beat_base + remaining);
        if (error_cnt == 0) begin
            for (int k = 0; remaining > 0; k++) begin
                exp_beats = (remaining > PART_LEN) ? PART_LEN : remaining;
                check_value("dn_awaddr", u_slave.aw_addr_q[piece_base + k],
                            tbl_addr[row] + addr_t'(k * PART_LEN * BEAT_BYTES));
                check_value("dn_awlen", u_slave.aw_len_q[piece_base + k], exp_beats - 1);
                for (int b = 0; b < exp_beats; b++) begin
                    check_value("dn_wdata", u_slave.w_data_q[beat_base + beat_i],
                                tbl_addr[row] + data_t'(beat_i));
                    check_value("dn_wlast", u_slave.w_last_q[beat_base + beat_i],
                                (b == exp_beats - 1));
                    beat_i++;
                end
                remaining -= exp_beats;
            end
        end
    endtask

    // AWREADY stays low while a burst is open and BVALID waits for all pieces
    always @(posedge clock) begin
        if (rst_n) begin
            if (busy) begin
                check_value("up_awready", up_awready, 1'b0);
            end
            if (up_bvalid && (u_slave.b_count < b_expect_total)) begin
                error_cnt++;
                $display("up_bvalid was raised before every piece had its response");
            end
            if (up_awvalid && up_awready) begin
                busy = 1'b1;
            end
            if (up_bvalid && up_bready) begin
                busy = 1'b0;
                up_b_count++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        int total_beats;
        int piece_base;
        int beat_base;
        int n_beats;
        rst_n      = 1'b0;
        up_awvalid = 1'b0;
        up_awaddr  = '0;
        up_awlen   = '0;
        up_wvalid  = 1'b0;
        up_wdata   = '0;
        up_wlast   = 1'b0;
        up_bready  = 1'b0;
        fail_index = -1;
        set_row(0, 32'h0000_1000, 8'd0,   -1, resp_okay);
        set_row(1, 32'h0000_2000, 8'd2,   -1, resp_okay);
        set_row(2, 32'h0000_3000, 8'd7,   -1, resp_okay);
        set_row(3, 32'h0000_4000, 8'd10,   2, resp_slverr);
        set_row(4, 32'h0001_0000, 8'd255, -1, resp_okay);
        set_row(5, 32'h0000_5004, 8'd3,    0, resp_slverr);
        set_row(6, 32'h0000_6000, 8'd7,    1, resp_slverr);
        total_beats = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total_beats += int'(tbl_len[r]) + 1;
        end
        cycle_limit = total_beats * 20 + 200;
        piece_base  = 0;
        beat_base   = 0;
        repeat (4) @(negedge clock);
        rst_n = 1'b1;
        for (int row = 0; row < N_ROWS; row++) begin
            n_beats        = int'(tbl_len[row]) + 1;
            fail_index     = (tbl_fail[row] < 0) ? -1 : piece_base + tbl_fail[row];
            b_expect_total = piece_base + (n_beats + PART_LEN - 1) / PART_LEN;
            send_request(tbl_addr[row], tbl_len[row]);
            send_beats(tbl_addr[row], n_beats);
            take_response(tbl_resp[row]);
            check_burst(row, piece_base, beat_base);
            piece_base = b_expect_total;
            beat_base += n_beats;
        end
        // Idle tail with BREADY open to catch a stray response
        @(negedge clock);
        up_bready = 1'b1;
        repeat (20) @(posedge clock);
        check_value("up_b count", up_b_count, N_ROWS);
        $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/axi_bus_pkg.sv
rtl/partition_pkg.sv
rtl/wr_beat_splitter.sv
rtl/wr_partition_ctrl.sv
rtl/axi_wr_partition_top.sv
verification/axi_wr_slave_model.sv
verification/tb_axi_wr_partition.sv
